// File: src/poly_pkg.sv
// widths, vector typedefs, buffer and queue depths, FSM state enums

package poly_pkg;

	// --------------------
	// widths and depths
	localparam int ADDR_W     = 10;
	localparam int BUF_DEPTH  = 1024;
	localparam int COEF_W     = 16;
	localparam int ACC_W      = 32;
	localparam int DEG_W      = 5;
	localparam int CNT_W      = 5;
	localparam int FIFO_DEPTH = 4;

	// --------------------
	// vector types
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [COEF_W-1:0] coef_t;
	typedef logic [COEF_W-1:0] point_t;
	typedef logic [ACC_W-1:0]  acc_t;
	typedef logic [DEG_W-1:0]  deg_t;
	typedef logic [CNT_W-1:0]  count_t;

	// --------------------
	// state machines
	typedef enum logic [2:0]
	{
		seq_idle,
		seq_issue,
		seq_wait,
		seq_next,
		seq_done
	} seq_state_t;

	typedef enum logic [1:0]
	{
		h_idle,
		h_read,
		h_last
	} horner_state_t;

endpackage

// File: src/coef_ram.sv
// coefficient buffer, one write port and one registered read port

`timescale 1ns/1ps

module coef_ram
(
	input  logic             clk,
	input  logic             load_en,
	input  poly_pkg::addr_t  load_addr,
	input  poly_pkg::coef_t  load_data,
	input  logic             rd_en,
	input  poly_pkg::addr_t  rd_addr,
	output poly_pkg::coef_t  rd_data
);

	poly_pkg::coef_t mem [poly_pkg::BUF_DEPTH];

	// host side write.
	always_ff @(posedge clk)
	begin
		if (load_en)
		begin
			mem[load_addr] <= load_data;
		end
	end

	// data is valid one cycle after rd_en.
	always_ff @(posedge clk)
	begin
		if (rd_en)
		begin
			rd_data <= mem[rd_addr];
		end
	end

endmodule

// File: src/horner_unit.sv
// Horner evaluator streaming coefficients from the buffer, highest power first

`timescale 1ns/1ps

module horner_unit
(
	input  logic             clk,
	input  logic             rst,
	input  logic             abort,
	input  logic             eval_start,
	input  poly_pkg::addr_t  eval_base,
	input  poly_pkg::point_t x,
	input  poly_pkg::deg_t   degree,
	output logic             rd_en,
	output poly_pkg::addr_t  rd_addr,
	input  poly_pkg::coef_t  rd_data,
	output logic             eval_done,
	output poly_pkg::acc_t   eval_result
);

	poly_pkg::horner_state_t state;
	poly_pkg::deg_t          remain;   // reads left after the current one.
	poly_pkg::acc_t          acc;
	logic                    rd_valid;
	logic                    rd_last;

	assign rd_en       = (state == poly_pkg::h_read);
	assign eval_result = acc;

	// --------------------
	// control
	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state     <= poly_pkg::h_idle;
			remain    <= '0;
			rd_valid  <= 1'b0;
			rd_last   <= 1'b0;
			eval_done <= 1'b0;
		end
		else if (abort)
		begin
			state     <= poly_pkg::h_idle;
			rd_valid  <= 1'b0;
			rd_last   <= 1'b0;
			eval_done <= 1'b0;
		end
		else
		begin
			rd_valid  <= rd_en;
			rd_last   <= rd_en && (remain == '0);
			eval_done <= rd_last;   // last word folded in this edge.
			case (state)
				poly_pkg::h_idle:
				begin
					if (eval_start)
					begin
						remain <= degree;
						state  <= poly_pkg::h_read;
					end
				end
				poly_pkg::h_read:
				begin
					if (remain == '0)
					begin
						state <= poly_pkg::h_last;
					end
					else
					begin
						remain <= remain - 1'b1;
					end
				end
				poly_pkg::h_last:
				begin
					if (rd_last)
					begin
						state <= poly_pkg::h_idle;
					end
				end
				default:
				begin
					state <= poly_pkg::h_idle;
				end
			endcase
		end
	end

	// --------------------
	// datapath
	always_ff @(posedge clk)
	begin
		if (state == poly_pkg::h_idle && eval_start)
		begin
			rd_addr <= eval_base + poly_pkg::addr_t'(degree);
			acc     <= '0;
		end
		else
		begin
			if (rd_en)
			begin
				rd_addr <= rd_addr - 1'b1;   // walk down to base.
			end
			if (rd_valid)
			begin
				acc <= acc * poly_pkg::acc_t'(x) + poly_pkg::acc_t'(rd_data);
			end
		end
	end

endmodule

// File: src/block_sequencer.sv
// block FSM running Horner evaluations over consecutive coefficient windows

`timescale 1ns/1ps

module block_sequencer
(
	input  logic             clk,
	input  logic             rst,
	input  logic             abort,
	input  logic             start_valid,
	output logic             start_ready,
	input  poly_pkg::addr_t  base_addr,
	input  poly_pkg::point_t x,
	input  poly_pkg::deg_t   degree,
	input  poly_pkg::count_t count,
	input  logic             space,
	output logic             eval_start,
	output poly_pkg::addr_t  eval_base,
	output poly_pkg::point_t eval_x,
	output poly_pkg::deg_t   eval_degree,
	input  logic             eval_done,
	input  poly_pkg::acc_t   eval_result,
	output logic             push,
	output poly_pkg::acc_t   push_data,
	output logic             done
);

	poly_pkg::seq_state_t state;
	poly_pkg::seq_state_t next_state;
	poly_pkg::addr_t      base_q;
	poly_pkg::point_t     x_q;
	poly_pkg::deg_t       degree_q;
	poly_pkg::count_t     count_q;
	poly_pkg::count_t     win;      // current window j.
	logic                 accept;
	logic                 last_win;

	assign accept   = start_valid && start_ready;
	assign last_win = (poly_pkg::count_t'(win + 1'b1) == count_q);

	// --------------------
	// outputs
	assign start_ready = (state == poly_pkg::seq_idle);
	assign eval_start  = (state == poly_pkg::seq_issue) && space;
	assign eval_base   = base_q + poly_pkg::addr_t'(win);
	assign eval_x      = x_q;
	assign eval_degree = degree_q;
	assign push        = (state == poly_pkg::seq_wait) && eval_done;
	assign push_data   = eval_result;
	assign done        = (state == poly_pkg::seq_done);

	always_comb
	begin
		next_state = state;
		case (state)
			poly_pkg::seq_idle:
			begin
				if (accept)
				begin
					next_state = (count == '0) ? poly_pkg::seq_done : poly_pkg::seq_issue;
				end
			end
			poly_pkg::seq_issue:
			begin
				if (space)
				begin
					next_state = poly_pkg::seq_wait;   // slot reserved.
				end
			end
			poly_pkg::seq_wait:
			begin
				if (eval_done)
				begin
					next_state = poly_pkg::seq_next;
				end
			end
			poly_pkg::seq_next:
			begin
				next_state = last_win ? poly_pkg::seq_done : poly_pkg::seq_issue;
			end
			poly_pkg::seq_done:
			begin
				next_state = poly_pkg::seq_idle;
			end
			default:
			begin
				next_state = poly_pkg::seq_idle;
			end
		endcase
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			state <= poly_pkg::seq_idle;
			win   <= '0;
		end
		else if (abort)
		begin
			state <= poly_pkg::seq_idle;
			win   <= '0;
		end
		else
		begin
			state <= next_state;
			if (accept)
			begin
				win <= '0;
			end
			else if (state == poly_pkg::seq_next)
			begin
				win <= win + 1'b1;
			end
		end
	end

	// block parameters.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			base_q   <= base_addr;
			x_q      <= x;
			degree_q <= degree;
			count_q  <= count;
		end
	end

endmodule

// File: src/result_fifo.sv
// four-entry result queue with valid/ready output and synchronous clear

`timescale 1ns/1ps

module result_fifo
(
	input  logic           clk,
	input  logic           rst,
	input  logic           clear,
	input  logic           push,
	input  poly_pkg::acc_t push_data,
	output logic           space,
	output logic           res_valid,
	input  logic           res_ready,
	output poly_pkg::acc_t res_data
);

	poly_pkg::acc_t mem [poly_pkg::FIFO_DEPTH];

	logic [$clog2(poly_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(poly_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(poly_pkg::FIFO_DEPTH+1)-1:0] used;
	logic                                      wr;
	logic                                      rd;

	assign space     = (used < poly_pkg::FIFO_DEPTH);
	assign res_valid = (used != '0);
	assign res_data  = mem[rd_ptr];

	assign wr = push && space;
	assign rd = res_valid && res_ready;

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end
		else if (clear)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end
		else
		begin
			if (wr)
			begin
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth.
			end
			if (rd)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr && !rd)
			begin
				used <= used + 1'b1;
			end
			else if (rd && !wr)
			begin
				used <= used - 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr)
		begin
			mem[wr_ptr] <= push_data;
		end
	end

endmodule

// File: src/poly_eval_top.sv
// top level with coefficient buffer, Horner unit, block sequencer and result queue

`timescale 1ns/1ps

module poly_eval_top
(
	input  logic             clk,
	input  logic             rst,
	input  logic             abort,
	input  logic             load_en,
	input  poly_pkg::addr_t  load_addr,
	input  poly_pkg::coef_t  load_data,
	input  logic             start_valid,
	output logic             start_ready,
	input  poly_pkg::addr_t  base_addr,
	input  poly_pkg::point_t x,
	input  poly_pkg::deg_t   degree,
	input  poly_pkg::count_t count,
	output logic             res_valid,
	input  logic             res_ready,
	output poly_pkg::acc_t   res_data,
	output logic             done
);

	logic             eval_start;
	poly_pkg::addr_t  eval_base;
	poly_pkg::point_t eval_x;
	poly_pkg::deg_t   eval_degree;
	logic             eval_done;
	poly_pkg::acc_t   eval_result;
	logic             rd_en;
	poly_pkg::addr_t  rd_addr;
	poly_pkg::coef_t  rd_data;
	logic             push;
	poly_pkg::acc_t   push_data;
	logic             space;

	coef_ram u_coef_ram
	(
		.clk       (clk),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

	horner_unit u_horner_unit
	(
		.clk         (clk),
		.rst         (rst),
		.abort       (abort),
		.eval_start  (eval_start),
		.eval_base   (eval_base),
		.x           (eval_x),
		.degree      (eval_degree),
		.rd_en       (rd_en),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.eval_done   (eval_done),
		.eval_result (eval_result)
	);

	block_sequencer u_block_sequencer
	(
		.clk         (clk),
		.rst         (rst),
		.abort       (abort),
		.start_valid (start_valid),
		.start_ready (start_ready),
		.base_addr   (base_addr),
		.x           (x),
		.degree      (degree),
		.count       (count),
		.space       (space),
		.eval_start  (eval_start),
		.eval_base   (eval_base),
		.eval_x      (eval_x),
		.eval_degree (eval_degree),
		.eval_done   (eval_done),
		.eval_result (eval_result),
		.push        (push),
		.push_data   (push_data),
		.done        (done)
	);

	// abort also flushes queued results.
	result_fifo u_result_fifo
	(
		.clk       (clk),
		.rst       (rst),
		.clear     (abort),
		.push      (push),
		.push_data (push_data),
		.space     (space),
		.res_valid (res_valid),
		.res_ready (res_ready),
		.res_data  (res_data)
	);

endmodule

// File: bench/tb_clock.sv
// free running testbench clock

`timescale 1ns/1ps

module tb_clock
#(
	parameter int PERIOD_NS = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD_NS / 2) clk = ~clk;   // 4 ns period.

endmodule

// File: bench/poly_eval_checker.sv
// concurrent assertions on start handshake, result stream, done pulse and Horner latency

`timescale 1ns/1ps

module poly_eval_checker
(
	input logic                 clk,
	input logic                 rst,
	input logic                 abort,
	input logic                 start_valid,
	input logic                 start_ready,
	input logic                 res_valid,
	input logic                 res_ready,
	input poly_pkg::acc_t       res_data,
	input logic                 done,
	input logic                 eval_start,
	input logic                 eval_done,
	input poly_pkg::deg_t       eval_degree
);

	logic [6:0] since;   // cycles since eval_start.
	logic [6:0] lat;
	logic       busy;
	logic       in_block;   // between start handshake and done.

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			busy  <= 1'b0;
			since <= '0;
			lat   <= '0;
		end
		else if (abort)
		begin
			busy <= 1'b0;
		end
		else if (eval_start)
		begin
			busy  <= 1'b1;
			since <= 7'd1;
			lat   <= 7'(eval_degree) + 7'd3;
		end
		else if (busy)
		begin
			since <= since + 7'd1;
			if (eval_done)
			begin
				busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk, negedge rst)
	begin
		if (!rst)
		begin
			in_block <= 1'b0;
		end
		else if (abort || done)
		begin
			in_block <= 1'b0;
		end
		else if (start_valid && start_ready)
		begin
			in_block <= 1'b1;
		end
	end

	// --------------------
	a_start_idle: assert property (@(posedge clk) disable iff (!rst)
		in_block |-> !start_ready)
		else $error("start_ready high while a block is running");

	a_res_stable: assert property (@(posedge clk) disable iff (!rst || abort)
		(res_valid && !res_ready) |=> (res_valid && $stable(res_data)))
		else $error("res_data changed while stalled");

	a_done_pulse: assert property (@(posedge clk) disable iff (!rst)
		done |=> !done)
		else $error("done longer than one cycle");

	a_eval_early: assert property (@(posedge clk) disable iff (!rst || abort)
		eval_done |-> (busy && since == lat))
		else $error("eval_done at the wrong cycle");

	a_eval_late: assert property (@(posedge clk) disable iff (!rst || abort)
		(busy && since == lat) |-> eval_done)
		else $error("eval_done missing after N+3 cycles");

endmodule

bind poly_eval_top poly_eval_checker u_poly_eval_checker
(
	.clk         (clk),
	.rst         (rst),
	.abort       (abort),
	.start_valid (start_valid),
	.start_ready (start_ready),
	.res_valid   (res_valid),
	.res_ready   (res_ready),
	.res_data    (res_data),
	.done        (done),
	.eval_start  (eval_start),
	.eval_done   (eval_done),
	.eval_degree (eval_degree)
);

// File: bench/poly_eval_tb.sv
// directed tests, buffer model, result monitor, watchdog and final report

`timescale 1ns/1ps

module poly_eval_tb;

	localparam int CLK_NS       = 4;
	localparam int RESET_CYC    = 10;
	localparam int LOAD_CYC     = 1024 + 64;
	// summed worst case per test of count*(degree+8)+20 plus stalls.
	localparam int BLOCK_CYC    = 149 + 152 + 160 + 85 + 220;
	localparam int TIMEOUT_CYC  = 2 * (RESET_CYC + LOAD_CYC + BLOCK_CYC);

	logic        clk;
	logic        rst;
	logic        abort;
	logic        load_en;
	logic [9:0]  load_addr;
	logic [15:0] load_data;
	logic        start_valid;
	logic        start_ready;
	logic [9:0]  base_addr;
	logic [15:0] x;
	logic [4:0]  degree;
	logic [4:0]  count;
	logic        res_valid;
	logic        res_ready;
	logic [31:0] res_data;
	logic        done;

	integer      seed;
	int          errors;
	int          done_cnt;
	logic [15:0] model_mem [1024];
	logic [31:0] got_q [$];
	logic [31:0] exp_q [$];

	tb_clock #(.PERIOD_NS(CLK_NS)) u_tb_clock (.clk(clk));

	poly_eval_top u_poly_eval_top
	(
		.clk         (clk),
		.rst         (rst),
		.abort       (abort),
		.load_en     (load_en),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.start_valid (start_valid),
		.start_ready (start_ready),
		.base_addr   (base_addr),
		.x           (x),
		.degree      (degree),
		.count       (count),
		.res_valid   (res_valid),
		.res_ready   (res_ready),
		.res_data    (res_data),
		.done        (done)
	);

	// result stream and done monitor.
	always @(posedge clk)
	begin
		if (res_valid && res_ready)
		begin
			got_q.push_back(res_data);
		end
		if (done)
		begin
			done_cnt++;
		end
	end

	initial
	begin
		#(TIMEOUT_CYC * CLK_NS);
		$display("timeout: the tests did not finish in %0d cycles", TIMEOUT_CYC);
		$display("SIMULATION FAILED");
		$finish;
	end

	// --------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("Error: %s got 0x%h expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// Horner over window base+j .. base+j+n with the highest power on top.
	function automatic logic [31:0] model_window(input logic [9:0] base, input int j,
		input int n, input logic [15:0] xv);
		logic [31:0] acc;
		logic [9:0]  a;
		acc = 32'h0;
		for (int k = n; k >= 0; k--)
		begin
			a   = base + 10'(j + k);
			acc = acc * {16'h0, xv} + {16'h0, model_mem[a]};
		end
		return acc;
	endfunction

	task automatic load_coef(input logic [9:0] a, input logic [15:0] d);
		@(posedge clk);
		load_en   <= 1'b1;
		load_addr <= a;
		load_data <= d;
		model_mem[a] = d;
	endtask

	task automatic end_load();
		@(posedge clk);
		load_en <= 1'b0;
	endtask

	task automatic issue_start(input logic [9:0] base, input logic [15:0] xv,
		input logic [4:0] deg, input logic [4:0] cnt);
		int n;
		n = 0;
		@(posedge clk);
		start_valid <= 1'b1;
		base_addr   <= base;
		x           <= xv;
		degree      <= deg;
		count       <= cnt;
		do
		begin
			@(posedge clk);
			n++;
		end while (!start_ready && n < 100);
		start_valid <= 1'b0;
		if (!start_ready)
		begin
			$display("start was not accepted within 100 cycles");
			errors++;
		end
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		while (done_cnt == 0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (done_cnt == 0)
		begin
			$display("no done pulse within %0d cycles", limit);
			errors++;
		end
	endtask

	task automatic wait_results(input int want, input int limit);
		int n;
		n = 0;
		while (got_q.size() < want && n < limit)
		begin
			@(posedge clk);
			n++;
		end
	endtask

	task automatic expect_block(input logic [9:0] base, input logic [15:0] xv,
		input int deg, input int cnt);
		exp_q.delete();
		for (int j = 0; j < cnt; j++)
		begin
			exp_q.push_back(model_window(base, j, deg, xv));
		end
	endtask

	task automatic compare_results(input int cnt);
		check_value("result_count", got_q.size(), cnt);
		for (int i = 0; i < cnt && i < got_q.size(); i++)
		begin
			check_value("res_data", got_q[i], exp_q[i]);
		end
	endtask

	task automatic run_block(input logic [9:0] base, input logic [15:0] xv,
		input int deg, input int cnt);
		int limit;
		limit = cnt * (deg + 8) + 50;
		expect_block(base, xv, deg, cnt);
		got_q.delete();
		done_cnt = 0;
		issue_start(base, xv, 5'(deg), 5'(cnt));
		wait_done(limit);
		wait_results(cnt, limit);
		repeat (4) @(posedge clk);
		compare_results(cnt);
		check_value("done_count", done_cnt, 1);
	endtask

	// --------------------
	task automatic test_single();
		int degs [4] = '{0, 1, 5, 31};
		foreach (degs[i])
		begin
			run_block(10'($random(seed)), 16'($random(seed)), degs[i], 1);
		end
	endtask

	task automatic test_windows();
		run_block(10'($random(seed)), 16'($random(seed)), 3, 12);
	endtask

	task automatic test_backpressure();
		logic [9:0]  base;
		logic [15:0] xv;
		int          n;
		base = 10'($random(seed));
		xv   = 16'($random(seed));
		expect_block(base, xv, 2, 10);
		got_q.delete();
		done_cnt = 0;
		@(posedge clk);
		res_ready <= 1'b0;
		issue_start(base, xv, 5'd2, 5'd10);
		n = 0;
		while (u_poly_eval_top.u_result_fifo.used != 4 && n < 100)
		begin
			@(posedge clk);
			n++;
		end
		repeat (20) @(posedge clk);   // stall must hold.
		check_value("fifo_used", 32'(u_poly_eval_top.u_result_fifo.used), 4);
		check_value("start_ready", start_ready, 0);
		check_value("done_count", done_cnt, 0);
		check_value("res_valid", res_valid, 1);
		res_ready <= 1'b1;
		wait_done(200);
		wait_results(10, 50);
		repeat (4) @(posedge clk);
		compare_results(10);
		check_value("done_count", done_cnt, 1);
	endtask

	task automatic test_zero_and_wrap();
		logic [9:0] a;
		run_block(10'($random(seed)), 16'($random(seed)), 4, 0);
		for (int i = 0; i < 12; i++)
		begin
			a = 10'd1018 + 10'(i);   // crosses the top of the buffer.
			load_coef(a, 16'hffff);
		end
		end_load();
		run_block(10'd1018, 16'hffff, 7, 3);
	endtask

	task automatic test_abort();
		logic [9:0]  base;
		logic [15:0] xv;
		int          n;
		int          kept;
		base = 10'($random(seed));
		xv   = 16'($random(seed));
		expect_block(base, xv, 4, 8);
		got_q.delete();
		done_cnt = 0;
		issue_start(base, xv, 5'd4, 5'd8);
		wait_results(2, 100);
		abort <= 1'b1;
		@(posedge clk);
		abort <= 1'b0;
		@(negedge clk);
		kept = got_q.size();
		repeat (40) @(posedge clk);
		@(negedge clk);
		check_value("result_count", got_q.size(), kept);
		check_value("done_count", done_cnt, 0);
		check_value("start_ready", start_ready, 1);
		for (int i = 0; i < kept; i++)
		begin
			check_value("res_data", got_q[i], exp_q[i]);
		end
		run_block(10'($random(seed)), 16'($random(seed)), 3, 4);
	endtask

	// --------------------
	initial
	begin
		seed        = 39993;
		errors      = 0;
		done_cnt    = 0;
		rst         = 1'b0;
		abort       = 1'b0;
		load_en     = 1'b0;
		load_addr   = '0;
		load_data   = '0;
		start_valid = 1'b0;
		base_addr   = '0;
		x           = '0;
		degree      = '0;
		count       = '0;
		res_ready   = 1'b1;
		repeat (RESET_CYC) @(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < 1024; i++)
		begin
			load_coef(10'(i), 16'($random(seed)));
		end
		end_load();
		test_single();
		test_windows();
		test_backpressure();
		test_zero_and_wrap();
		test_abort();
		repeat (4) @(posedge clk);
		$display("checks done, %0d errors", errors);
		if (errors == 0)
		begin
			$display("SIMULATION PASSED");
		end
		else
		begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: tb.f
src/poly_pkg.sv
src/coef_ram.sv
src/horner_unit.sv
src/block_sequencer.sv
src/result_fifo.sv
src/poly_eval_top.sv
bench/tb_clock.sv
bench/poly_eval_checker.sv
bench/poly_eval_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the polynomial evaluator testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module poly_eval_tb \
	--Mdir obj_dir -o poly_eval_sim \
	-f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/poly_eval_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
